//--- rv32mc.f
common/rvIsaPkg.sv
common/coreCfgPkg.sv
common/ctrlIf.sv
hw/decode/controlFsm.sv
hw/decode/instrDecode.sv
hw/execute/regFile.sv
hw/execute/alu.sv
hw/result/resultStage.sv
hw/rvCore.sv
testbench/rvCore_assertions.sv
testbench/rvCoreTb.sv

//--- Bender.yml
package:
  name: rv32mc

sources:
  - common/rvIsaPkg.sv
  - common/coreCfgPkg.sv
  - common/ctrlIf.sv
  - hw/decode/controlFsm.sv
  - hw/decode/instrDecode.sv
  - hw/execute/regFile.sv
  - hw/execute/alu.sv
  - hw/result/resultStage.sv
  - hw/rvCore.sv
  - target: test
    files:
      - testbench/rvCore_assertions.sv
      - testbench/rvCoreTb.sv

//--- testbench/rvCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module rvCoreTb;

    localparam int          bodyLen    = 200;
    localparam int          memWords   = 512;
    localparam int          runTimeout = 20000;
    localparam logic [31:0] dataBase   = 32'h0000_0400;  // 128-word data window
    localparam logic [31:0] resultBase = 32'h0000_0700;  // Register dump area
    localparam logic [31:0] loopAddr   = 32'(4 * (bodyLen + 31));

    logic            clk;
    logic            reset;
    rvIsaPkg::word_t wbAdr;
    rvIsaPkg::word_t wbDatW;
    rvIsaPkg::word_t wbDatR;
    logic            wbWe;
    logic [3:0]      wbSel;
    logic            wbCyc;
    logic            wbStb;
    logic            wbAck;
    rvIsaPkg::word_t retired;

    rvIsaPkg::word_t mem [0:memWords-1];
    rvIsaPkg::word_t modelMem [0:memWords-1];
    rvIsaPkg::word_t modelRegs [0:31];
    rvIsaPkg::word_t fetchTrace [$];
    rvIsaPkg::word_t storeAddrQ [$];
    rvIsaPkg::word_t storeDataQ [$];
    logic [31:0]     lfsrState;
    int              fetchIdx;
    int              waitLeft;
    logic            loopReached;

    rvCore dut (
        .clk     (clk),
        .reset   (reset),
        .wbAdr   (wbAdr),
        .wbDatW  (wbDatW),
        .wbDatR  (wbDatR),
        .wbWe    (wbWe),
        .wbSel   (wbSel),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbAck   (wbAck),
        .retired (retired)
    );

    always #4 clk = ~clk;

    task automatic stopOnFailure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic valueError(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        stopOnFailure($sformatf("** Error %s: expected %08h, actual %08h",
                                testName, expected, actual));
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic rvIsaPkg::word_t fillWord(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic rvIsaPkg::word_t encR(input logic alt, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rvIsaPkg::OP};
    endfunction

    function automatic rvIsaPkg::word_t encI(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rvIsaPkg::word_t encS(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvIsaPkg::STORE};
    endfunction

    function automatic rvIsaPkg::word_t encB(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvIsaPkg::BRANCH};
    endfunction

    function automatic rvIsaPkg::word_t encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::JAL};
    endfunction

    task automatic buildProgram();
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [31:0] dataAddr;
        int          skip;
        for (int a = 0; a < memWords; a++) begin
            mem[a] = fillWord(32'(a * 4));
        end
        for (int i = 0; i < bodyLen; i++) begin
            kind     = 3'(randBits(3));
            rd       = 5'(randBits(5));
            rs1      = 5'(randBits(5));
            rs2      = 5'(randBits(5));
            f3       = 3'(randBits(3));
            alt      = randBits(1) != 0;
            imm      = 12'(randBits(12));
            dataAddr = dataBase + {imm[6:0], 2'b00};
            skip     = 1 + int'(randBits(3));  // Forward targets only
            if (i + skip > bodyLen) begin
                skip = bodyLen - i;
            end
            case (kind)
                3'd0, 3'd1: mem[i] = encR(alt && (f3 == 3'd0 || f3 == 3'd5), rs2, rs1, f3, rd);
                3'd2, 3'd3: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm = {1'b0, alt && (f3 == 3'd5), 5'b0, imm[4:0]};  // Shift amount
                    end
                    mem[i] = encI(imm, rs1, f3, rd, rvIsaPkg::OPIMM);
                end
                3'd4: mem[i] = encI(dataAddr[11:0], 5'd0, 3'b010, rd, rvIsaPkg::LOAD);
                3'd5: mem[i] = encS(dataAddr[11:0], rs2, 5'd0);
                3'd6: begin
                    if (f3 == 3'd2 || f3 == 3'd3) begin
                        f3 = f3 - 3'd2;  // No branch with these codes
                    end
                    mem[i] = encB(13'(4 * skip), rs2, rs1, f3);
                end
                default: begin
                    if (alt) begin
                        mem[i] = encJ(21'(4 * skip), rd);
                    end else begin
                        mem[i] = encI(12'(4 * (i + skip)), 5'd0, 3'b000, rd, rvIsaPkg::JALR);
                    end
                end
            endcase
        end
        for (int r = 1; r < 32; r++) begin
            mem[bodyLen + r - 1] = encS(12'(resultBase + 4 * (r - 1)), 5'(r), 5'd0);
        end
        mem[bodyLen + 31] = encJ(21'd0, 5'd0);  // Self loop
    endtask

    function automatic rvIsaPkg::word_t aluModel(input logic [2:0] f3, input logic alt,
                                                 input rvIsaPkg::word_t a,
                                                 input rvIsaPkg::word_t b);
        rvIsaPkg::word_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input rvIsaPkg::word_t a,
                                         input rvIsaPkg::word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic void writeReg(input logic [4:0] rd, input rvIsaPkg::word_t v);
        if (rd != 5'd0) begin
            modelRegs[rd] = v;
        end
    endfunction

    task automatic runModel();
        rvIsaPkg::word_t pcM;
        rvIsaPkg::word_t w;
        rvIsaPkg::word_t a;
        rvIsaPkg::word_t b;
        rvIsaPkg::word_t immI;
        rvIsaPkg::word_t immS;
        rvIsaPkg::word_t immB;
        rvIsaPkg::word_t immJ;
        rvIsaPkg::word_t addr;
        rvIsaPkg::word_t nextPc;
        pcM = coreCfgPkg::resetPc;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        for (int k = 0; k < memWords; k++) begin
            modelMem[k] = mem[k];
        end
        while (pcM != loopAddr && fetchTrace.size() < 1000) begin
            w = modelMem[pcM[10:2]];
            fetchTrace.push_back(pcM);
            a      = modelRegs[w[19:15]];
            b      = modelRegs[w[24:20]];
            immI   = {{20{w[31]}}, w[31:20]};
            immS   = {{20{w[31]}}, w[31:25], w[11:7]};
            immB   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            immJ   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            nextPc = pcM + 32'd4;
            case (w[6:0])
                rvIsaPkg::OP:    writeReg(w[11:7], aluModel(w[14:12], w[30], a, b));
                rvIsaPkg::OPIMM: writeReg(w[11:7],
                                          aluModel(w[14:12], w[30] && w[14:12] == 3'd5, a, immI));
                rvIsaPkg::LOAD: begin
                    addr = a + immI;
                    writeReg(w[11:7], modelMem[addr[10:2]]);
                end
                rvIsaPkg::STORE: begin
                    addr = a + immS;
                    storeAddrQ.push_back(addr);
                    storeDataQ.push_back(b);
                    modelMem[addr[10:2]] = b;
                end
                rvIsaPkg::BRANCH: begin
                    if (branchTaken(w[14:12], a, b)) begin
                        nextPc = pcM + immB;
                    end
                end
                rvIsaPkg::JAL: begin
                    writeReg(w[11:7], pcM + 32'd4);
                    nextPc = pcM + immJ;
                end
                rvIsaPkg::JALR: begin
                    nextPc = (a + immI) & ~32'd1;
                    writeReg(w[11:7], pcM + 32'd4);
                end
                default: begin
                end
            endcase
            pcM = nextPc;
        end
    endtask

    task automatic serveRequest();
        rvIsaPkg::word_t expected;
        assert (wbAdr < 32'(memWords * 4))
        else stopOnFailure("bus access outside the memory model");
        assert (wbSel == 4'hf) else valueError("byte select", 32'hf, 32'(wbSel));
        if (wbWe) begin
            assert (storeAddrQ.size() > 0)
            else stopOnFailure("the core made a store that the model never made");
            assert (wbAdr == storeAddrQ[0]) else valueError("store address", storeAddrQ[0], wbAdr);
            assert (wbDatW == storeDataQ[0]) else valueError("store data", storeDataQ[0], wbDatW);
            void'(storeAddrQ.pop_front());
            void'(storeDataQ.pop_front());
            mem[wbAdr[10:2]] = wbDatW;
        end else begin
            if (wbAdr < dataBase) begin  // Program area holds only fetches
                expected = (fetchIdx < fetchTrace.size()) ? fetchTrace[fetchIdx] : loopAddr;
                assert (wbAdr == expected) else valueError("fetch address", expected, wbAdr);
                fetchIdx++;
                if (wbAdr == loopAddr && !loopReached) begin
                    loopReached = 1'b1;
                    assert (retired == 32'(fetchTrace.size()))
                    else valueError("retired count", 32'(fetchTrace.size()), retired);
                end
            end
            wbDatR = mem[wbAdr[10:2]];
        end
    endtask

    // Slave answers after 0 to 3 wait cycles
    always @(negedge clk) begin
        if (reset) begin
            wbAck    = 1'b0;
            waitLeft = -1;
        end else if (wbAck) begin
            wbAck = 1'b0;  // Taken at the last rising edge
        end else if (wbCyc && wbStb) begin
            if (waitLeft < 0) begin
                waitLeft = int'(randBits(2));
            end
            if (waitLeft == 0) begin
                serveRequest();
                wbAck    = 1'b1;
                waitLeft = -1;
            end else begin
                waitLeft--;
            end
        end
    end

    always @(negedge clk) begin
        assert (dut.checks.failCount == 0)
        else stopOnFailure("a Wishbone protocol assertion fired");
    end

    initial begin
        int cycles;
        clk         = 1'b0;
        reset       = 1'b1;
        wbDatR      = '0;
        wbAck       = 1'b0;
        lfsrState   = 32'hab573679;
        fetchIdx    = 0;
        waitLeft    = -1;
        loopReached = 1'b0;
        buildProgram();
        runModel();
        repeat (3) begin
            @(posedge clk);
        end
        @(negedge clk);
        reset = 1'b0;
        assert (!wbCyc && !wbStb && !wbWe)
        else stopOnFailure("bus request active right after reset");
        assert (retired == '0) else valueError("retired after reset", 32'd0, retired);
        cycles = 0;
        while (!wbCyc && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        assert (wbCyc) else stopOnFailure("no fetch request after reset");
        assert (wbAdr == coreCfgPkg::resetPc)
        else valueError("first fetch address", coreCfgPkg::resetPc, wbAdr);
        cycles = 0;
        while (!loopReached && cycles < runTimeout) begin
            @(negedge clk);
            cycles++;
        end
        assert (loopReached) else stopOnFailure("timeout, the program never reached its end");
        assert (storeAddrQ.size() == 0) else stopOnFailure("the core made too few stores");
        for (int r = 1; r < 32; r++) begin
            assert (mem[int'(resultBase >> 2) + r - 1] == modelRegs[r])
            else valueError($sformatf("dump of x%0d", r), modelRegs[r],
                            mem[int'(resultBase >> 2) + r - 1]);
        end
        if (dut.checks.failCount == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            stopOnFailure("Wishbone protocol assertions fired during the run");
        end
    end

endmodule

`default_nettype wire

//--- testbench/rvCore_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module rvCore_assertions (
    input logic            clk,
    input logic            reset,
    input rvIsaPkg::word_t wbAdr,
    input rvIsaPkg::word_t wbDatW,
    input logic            wbWe,
    input logic            wbCyc,
    input logic            wbStb,
    input logic            wbAck
);

    int failCount = 0;  // Failed assertions so far

    stbWithCyc: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
    else begin
        failCount++;
        $error("stb high while cyc is low");
    end

    // Request fields frozen until the slave answers
    holdUntilAck: assert property (@(posedge clk) disable iff (reset)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW))
    else begin
        failCount++;
        $error("Wishbone request changed or dropped before ack");
    end

    idleAfterReset: assert property (@(posedge clk) reset |=> !wbCyc && !wbStb)
    else begin
        failCount++;
        $error("cyc or stb high in the first cycle after reset");
    end

endmodule

bind rvCore rvCore_assertions checks (
    .clk    (clk),
    .reset  (reset),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbWe   (wbWe),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbAck  (wbAck)
);

`default_nettype wire

//--- hw/rvCore.sv
`timescale 1ns/10ps
`default_nettype none

module rvCore (
    input  logic            clk,
    input  logic            reset,
    output rvIsaPkg::word_t wbAdr,
    output rvIsaPkg::word_t wbDatW,
    input  rvIsaPkg::word_t wbDatR,
    output logic            wbWe,
    output logic [3:0]      wbSel,
    output logic            wbCyc,
    output logic            wbStb,
    input  logic            wbAck,
    output rvIsaPkg::word_t retired
);

    logic            irLoad;
    logic            pcUpdate;
    logic            wbEnable;
    logic            aluZero;
    logic            cmpLess;
    logic            cmpLessU;
    logic            wrEn;
    rvIsaPkg::word_t pc;
    rvIsaPkg::word_t aluResult;
    rvIsaPkg::word_t rs1Data;
    rvIsaPkg::word_t rs2Data;
    rvIsaPkg::word_t wrData;

    ctrlIf ctrl ();

    assign wbSel = 4'b1111;  // Word accesses only

    controlFsm u_controlFsm (
        .clk       (clk),
        .reset     (reset),
        .irLoad    (irLoad),
        .pcUpdate  (pcUpdate),
        .wbEnable  (wbEnable),
        .isLoad    (ctrl.isLoad),
        .isStore   (ctrl.isStore),
        .pc        (pc),
        .aluResult (aluResult),
        .storeData (rs2Data),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbWe      (wbWe),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbAck     (wbAck)
    );

    instrDecode u_instrDecode (
        .clk    (clk),
        .reset  (reset),
        .irLoad (irLoad),
        .wbDatR (wbDatR),
        .ctrl   (ctrl)
    );

    regFile u_regFile (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .wrEn    (wrEn),
        .wrData  (wrData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    alu u_alu (
        .ctrl      (ctrl),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .aluResult (aluResult),
        .aluZero   (aluZero),
        .cmpLess   (cmpLess),
        .cmpLessU  (cmpLessU)
    );

    resultStage u_resultStage (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .pcUpdate  (pcUpdate),
        .wbEnable  (wbEnable),
        .aluResult (aluResult),
        .aluZero   (aluZero),
        .cmpLess   (cmpLess),
        .cmpLessU  (cmpLessU),
        .memData   (wbDatR),
        .pc        (pc),
        .wrEn      (wrEn),
        .wrData    (wrData),
        .retired   (retired)
    );

endmodule

`default_nettype wire

//--- hw/result/resultStage.sv
`timescale 1ns/10ps
`default_nettype none

module resultStage (
    input  logic            clk,
    input  logic            reset,
    ctrlIf.res              ctrl,
    input  logic            pcUpdate,
    input  logic            wbEnable,
    input  rvIsaPkg::word_t aluResult,
    input  logic            aluZero,
    input  logic            cmpLess,
    input  logic            cmpLessU,
    input  rvIsaPkg::word_t memData,
    output rvIsaPkg::word_t pc,
    output logic            wrEn,
    output rvIsaPkg::word_t wrData,
    output rvIsaPkg::word_t retired
);

    rvIsaPkg::word_t pcPlus4;
    rvIsaPkg::word_t pcTarget;
    rvIsaPkg::word_t nextPc;
    rvIsaPkg::word_t memReg;
    logic            taken;

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + ctrl.imm;

    always_comb begin
        case (ctrl.branchFunct)
            rvIsaPkg::funct3Beq:  taken = aluZero;
            rvIsaPkg::funct3Bne:  taken = !aluZero;
            rvIsaPkg::funct3Blt:  taken = cmpLess;
            rvIsaPkg::funct3Bge:  taken = !cmpLess;
            rvIsaPkg::funct3Bltu: taken = cmpLessU;
            rvIsaPkg::funct3Bgeu: taken = !cmpLessU;
            default:              taken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.isJalr) begin
            nextPc = {aluResult[31:1], 1'b0};
        end else if (ctrl.isJump || (ctrl.isBranch && taken)) begin
            nextPc = pcTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= coreCfgPkg::resetPc;
            retired <= '0;
        end else if (pcUpdate) begin
            pc      <= nextPc;
            retired <= retired + 32'd1;  // One per instruction
        end
    end

    // Holds the read data of the ack cycle into WRITEBACK
    always_ff @(posedge clk) begin
        memReg <= memData;
    end

    always_comb begin
        case (ctrl.wbSel)
            coreCfgPkg::MEM:     wrData = memReg;
            coreCfgPkg::PCPLUS4: wrData = pcPlus4;
            default:             wrData = aluResult;
        endcase
    end

    assign wrEn = wbEnable && ctrl.regWrite && (ctrl.rd != '0);

endmodule

`default_nettype wire

//--- hw/execute/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    ctrlIf.exe              ctrl,
    input  rvIsaPkg::word_t rs1Data,
    input  rvIsaPkg::word_t rs2Data,
    output rvIsaPkg::word_t aluResult,
    output logic            aluZero,
    output logic            cmpLess,
    output logic            cmpLessU
);

    rvIsaPkg::word_t opB;
    logic [4:0]      shamt;

    assign opB   = (ctrl.opBSel == coreCfgPkg::IMM) ? ctrl.imm : rs2Data;
    assign shamt = opB[4:0];

    assign cmpLess  = $signed(rs1Data) < $signed(opB);
    assign cmpLessU = rs1Data < opB;

    always_comb begin
        case (ctrl.aluOp)
            rvIsaPkg::ADD:  aluResult = rs1Data + opB;
            rvIsaPkg::SUB:  aluResult = rs1Data - opB;
            rvIsaPkg::AND:  aluResult = rs1Data & opB;
            rvIsaPkg::OR:   aluResult = rs1Data | opB;
            rvIsaPkg::XOR:  aluResult = rs1Data ^ opB;
            rvIsaPkg::SLT:  aluResult = {31'b0, cmpLess};
            rvIsaPkg::SLTU: aluResult = {31'b0, cmpLessU};
            rvIsaPkg::SLL:  aluResult = rs1Data << shamt;
            rvIsaPkg::SRL:  aluResult = rs1Data >> shamt;
            rvIsaPkg::SRA:  aluResult = $signed(rs1Data) >>> shamt;
            default:        aluResult = rs1Data + opB;
        endcase
    end

    assign aluZero = (aluResult == '0);

endmodule

`default_nettype wire

//--- hw/execute/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic            clk,
    input  logic            reset,
    ctrlIf.exe              ctrl,
    input  logic            wrEn,
    input  rvIsaPkg::word_t wrData,
    output rvIsaPkg::word_t rs1Data,
    output rvIsaPkg::word_t rs2Data
);

    rvIsaPkg::word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (ctrl.rd != '0)) begin
            regs[ctrl.rd] <= wrData;
        end
    end

    assign rs1Data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
    assign rs2Data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

endmodule

`default_nettype wire

//--- hw/decode/instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
    input  logic            clk,
    input  logic            reset,
    input  logic            irLoad,
    input  rvIsaPkg::word_t wbDatR,
    ctrlIf.dec              ctrl
);

    rvIsaPkg::word_t   ir;
    rvIsaPkg::opcode_t opcode;
    rvIsaPkg::word_t   immI;
    rvIsaPkg::word_t   immS;
    rvIsaPkg::word_t   immB;
    rvIsaPkg::word_t   immJ;

    function automatic rvIsaPkg::aluOp_t decodeAluOp(input rvIsaPkg::funct3_t f3,
                                                     input logic alt, input logic regOp);
        rvIsaPkg::aluOp_t op;
        case (f3)
            rvIsaPkg::funct3AddSub: op = (alt && regOp) ? rvIsaPkg::SUB : rvIsaPkg::ADD;
            rvIsaPkg::funct3Sll:    op = rvIsaPkg::SLL;
            rvIsaPkg::funct3Slt:    op = rvIsaPkg::SLT;
            rvIsaPkg::funct3Sltu:   op = rvIsaPkg::SLTU;
            rvIsaPkg::funct3Xor:    op = rvIsaPkg::XOR;
            rvIsaPkg::funct3SrlSra: op = alt ? rvIsaPkg::SRA : rvIsaPkg::SRL;
            rvIsaPkg::funct3Or:     op = rvIsaPkg::OR;
            default:                op = rvIsaPkg::AND;
        endcase
        return op;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;  // Opcode zero decodes as a no-op
        end else if (irLoad) begin
            ir <= wbDatR;
        end
    end

    assign opcode = rvIsaPkg::opcode_t'(ir[6:0]);

    assign immI = {{20{ir[31]}}, ir[31:20]};
    assign immS = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign immB = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign immJ = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    assign ctrl.rs1         = ir[19:15];
    assign ctrl.rs2         = ir[24:20];
    assign ctrl.rd          = ir[11:7];
    assign ctrl.branchFunct = ir[14:12];

    always_comb begin
        ctrl.aluOp    = rvIsaPkg::ADD;
        ctrl.opBSel   = coreCfgPkg::REG;
        ctrl.wbSel    = coreCfgPkg::ALU;
        ctrl.imm      = immI;
        ctrl.regWrite = 1'b0;
        ctrl.isBranch = 1'b0;
        ctrl.isJump   = 1'b0;
        ctrl.isJalr   = 1'b0;
        ctrl.isLoad   = 1'b0;
        ctrl.isStore  = 1'b0;
        case (opcode)
            rvIsaPkg::OP: begin
                ctrl.aluOp    = decodeAluOp(ir[14:12], ir[30], 1'b1);
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::OPIMM: begin
                ctrl.aluOp    = decodeAluOp(ir[14:12], ir[30], 1'b0);
                ctrl.opBSel   = coreCfgPkg::IMM;
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::LOAD: begin
                ctrl.opBSel   = coreCfgPkg::IMM;
                ctrl.wbSel    = coreCfgPkg::MEM;
                ctrl.regWrite = 1'b1;
                ctrl.isLoad   = 1'b1;
            end
            rvIsaPkg::STORE: begin
                ctrl.opBSel  = coreCfgPkg::IMM;
                ctrl.imm     = immS;
                ctrl.isStore = 1'b1;
            end
            rvIsaPkg::BRANCH: begin
                ctrl.aluOp    = rvIsaPkg::SUB;  // Zero flag gives equality
                ctrl.imm      = immB;
                ctrl.isBranch = 1'b1;
            end
            rvIsaPkg::JAL: begin
                ctrl.imm      = immJ;
                ctrl.wbSel    = coreCfgPkg::PCPLUS4;
                ctrl.regWrite = 1'b1;
                ctrl.isJump   = 1'b1;
            end
            rvIsaPkg::JALR: begin
                ctrl.opBSel   = coreCfgPkg::IMM;
                ctrl.wbSel    = coreCfgPkg::PCPLUS4;
                ctrl.regWrite = 1'b1;
                ctrl.isJalr   = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/decode/controlFsm.sv
`timescale 1ns/10ps
`default_nettype none

module controlFsm (
    input  logic            clk,
    input  logic            reset,
    output logic            irLoad,
    output logic            pcUpdate,
    output logic            wbEnable,
    input  logic            isLoad,
    input  logic            isStore,
    input  rvIsaPkg::word_t pc,
    input  rvIsaPkg::word_t aluResult,
    input  rvIsaPkg::word_t storeData,
    output rvIsaPkg::word_t wbAdr,
    output rvIsaPkg::word_t wbDatW,
    output logic            wbWe,
    output logic            wbCyc,
    output logic            wbStb,
    input  logic            wbAck
);

    coreCfgPkg::state_t state;
    coreCfgPkg::state_t nextState;
    logic               busActive;  // Drives both cyc and stb
    logic               busDone;

    assign busDone = busActive && wbAck;

    always_comb begin
        nextState = state;
        case (state)
            coreCfgPkg::FETCH: begin
                if (busDone) begin
                    nextState = coreCfgPkg::DECODE;
                end
            end
            coreCfgPkg::DECODE: begin
                nextState = coreCfgPkg::EXECUTE;
            end
            coreCfgPkg::EXECUTE: begin
                if (isLoad || isStore) begin
                    nextState = coreCfgPkg::MEMORY;
                end else begin
                    nextState = coreCfgPkg::WRITEBACK;
                end
            end
            coreCfgPkg::MEMORY: begin
                if (busDone) begin
                    nextState = coreCfgPkg::WRITEBACK;
                end
            end
            coreCfgPkg::WRITEBACK: begin
                nextState = coreCfgPkg::FETCH;
            end
            default: begin
                nextState = coreCfgPkg::FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= coreCfgPkg::FETCH;
            busActive <= 1'b0;
        end else begin
            state     <= nextState;
            // Request held until ack and dropped the cycle after
            busActive <= (nextState == coreCfgPkg::FETCH) ||
                         (nextState == coreCfgPkg::MEMORY);
        end
    end

    assign irLoad   = (state == coreCfgPkg::FETCH) && busDone;
    assign pcUpdate = (state == coreCfgPkg::WRITEBACK);
    assign wbEnable = (state == coreCfgPkg::WRITEBACK);

    assign wbCyc  = busActive;
    assign wbStb  = busActive;
    assign wbWe   = busActive && (state == coreCfgPkg::MEMORY) && isStore;
    assign wbAdr  = (state == coreCfgPkg::MEMORY) ? aluResult : pc;  // Data or fetch address
    assign wbDatW = storeData;

endmodule

`default_nettype wire

//--- common/ctrlIf.sv
`timescale 1ns/10ps
`default_nettype none

interface ctrlIf;

    rvIsaPkg::aluOp_t   aluOp;
    coreCfgPkg::opBSel_t opBSel;
    coreCfgPkg::wbSel_t wbSel;
    logic               regWrite;
    logic               isBranch;
    logic               isJump;     // JAL
    logic               isJalr;
    logic               isLoad;
    logic               isStore;
    rvIsaPkg::funct3_t  branchFunct;
    rvIsaPkg::word_t    imm;
    rvIsaPkg::regAddr_t rs1;
    rvIsaPkg::regAddr_t rs2;
    rvIsaPkg::regAddr_t rd;

    modport dec (output aluOp, opBSel, wbSel, regWrite, isBranch, isJump, isJalr,
                 isLoad, isStore, branchFunct, imm, rs1, rs2, rd);

    modport exe (input rs1, rs2, rd, imm, opBSel, aluOp);

    modport res (input wbSel, regWrite, isBranch, isJump, isJalr, branchFunct, imm, rd);

endinterface

`default_nettype wire

//--- common/coreCfgPkg.sv
`default_nettype none

package coreCfgPkg;

    localparam logic [31:0] resetPc = 32'h0000_0000;  // First fetch address

    typedef enum logic [2:0] {
        FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK
    } state_t;

    typedef enum logic [1:0] {
        ALU, MEM, PCPLUS4
    } wbSel_t;

    typedef enum logic {
        REG, IMM
    } opBSel_t;

endpackage

`default_nettype wire

//--- common/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    typedef logic [31:0] word_t;   // Data, address or instruction word
    typedef logic [4:0]  regAddr_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OPIMM  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
    } aluOp_t;

    // Branch conditions
    localparam funct3_t funct3Beq  = 3'b000;
    localparam funct3_t funct3Bne  = 3'b001;
    localparam funct3_t funct3Blt  = 3'b100;
    localparam funct3_t funct3Bge  = 3'b101;
    localparam funct3_t funct3Bltu = 3'b110;
    localparam funct3_t funct3Bgeu = 3'b111;

    // ALU operations
    localparam funct3_t funct3AddSub = 3'b000;
    localparam funct3_t funct3Sll    = 3'b001;
    localparam funct3_t funct3Slt    = 3'b010;
    localparam funct3_t funct3Sltu   = 3'b011;
    localparam funct3_t funct3Xor    = 3'b100;
    localparam funct3_t funct3SrlSra = 3'b101;
    localparam funct3_t funct3Or     = 3'b110;
    localparam funct3_t funct3And    = 3'b111;

endpackage

`default_nettype wire
